// ==== src/fifo_pkg.sv ====
////////////////////////////////////////////////////////////
// fifo geometry and status types
////////////////////////////////////////////////////////////

package fifo_pkg;

	// entries held by each fifo
	localparam int DEPTH = 16;

	// address bits needed to index DEPTH entries
	localparam int PTR_W = $clog2(DEPTH);

	// read and write address into the storage array
	typedef logic [PTR_W-1:0] ptr_t;

	// occupancy from 0 up to DEPTH inclusive, one bit wider than the pointer
	typedef logic [PTR_W:0] count_t;

	// quarter fill level
	// 0 for the lowest quarter, 3 for the top quarter or full
	typedef logic [1:0] level_t;

	// almost full is raised once this many entries are held
	// one slot left, enough for a single write already in flight
	localparam count_t AFULL_AT = count_t'(DEPTH - 1);

endpackage

// ==== src/stream_pkg.sv ====
////////////////////////////////////////////////////////////
// data types of the lane sum stream
////////////////////////////////////////////////////////////

package stream_pkg;

	// lanes packed into one ingress word
	localparam int LANES = 4;

	// bits per lane
	localparam int LANE_W = 32;

	// full ingress word width
	localparam int WORD_W = LANES * LANE_W;

	// one lane of an ingress word
	typedef logic [LANE_W-1:0] lane_t;

	// lane sum, carried modulo 2^32 so it keeps the lane width
	typedef logic [LANE_W-1:0] sum_t;

	// ingress word
	// lane 0 sits in the low bits
	typedef struct packed {
		lane_t [LANES-1:0] lane;
	} word_t;

endpackage

// ==== src/sync_ram.sv ====
////////////////////////////////////////////////////////////
// fifo storage with one write port and one read port
////////////////////////////////////////////////////////////

module sync_ram #(
	parameter int WIDTH = 32
) (
	input  logic               clk,
	input  logic               wr,
	input  fifo_pkg::ptr_t     waddr,
	input  logic [WIDTH-1:0]   wdata,
	input  fifo_pkg::ptr_t     raddr,
	output logic [WIDTH-1:0]   rdata
);

	// DEPTH words, no reset on the contents
	logic [WIDTH-1:0] mem [fifo_pkg::DEPTH];

	// write port
	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= wdata;
		end
	end

	// registered read port
	// reads every cycle, the fifo decides when the result counts
	// read and write never hit the same slot while the fifo is used legally
	always_ff @(posedge clk) begin
		rdata <= mem[raddr];
	end

endmodule

// ==== src/sc_fifo.sv ====
////////////////////////////////////////////////////////////
// single clock fifo with guard bit flags
////////////////////////////////////////////////////////////

module sc_fifo #(
	parameter int WIDTH = 32
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               clr,
	input  logic               wr,
	input  logic [WIDTH-1:0]   wdata,
	input  logic               rd,
	output logic [WIDTH-1:0]   rdata,
	output logic               empty,
	output logic               full,
	output logic               almost_full,
	output fifo_pkg::level_t   level
);

	// pointers and their next values
	fifo_pkg::ptr_t wp;
	fifo_pkg::ptr_t rp;
	fifo_pkg::ptr_t wp_pl1;
	fifo_pkg::ptr_t rp_pl1;
	fifo_pkg::ptr_t wp_nx;
	fifo_pkg::ptr_t rp_nx;

	// guard bit, set when the write pointer catches up with the read pointer
	logic gb;
	logic gb_nx;

	// entry counter
	fifo_pkg::count_t cnt;
	fifo_pkg::count_t cnt_nx;

	// read side
	logic [WIDTH-1:0] ram_q;
	logic [WIDTH-1:0] hold;
	logic rd_q;

	////////////////////////////////////////////////////////////
	// storage
	////////////////////////////////////////////////////////////

	sync_ram #(
		.WIDTH (WIDTH)
	) i_sync_ram (
		.clk   (clk),
		.wr    (wr),
		.waddr (wp),
		.wdata (wdata),
		.raddr (rp),
		.rdata (ram_q)
	);

	////////////////////////////////////////////////////////////
	// next state of pointers, guard bit and counter
	////////////////////////////////////////////////////////////

	always_comb begin
		wp_pl1 = wp + fifo_pkg::ptr_t'(1);
		rp_pl1 = rp + fifo_pkg::ptr_t'(1);
		wp_nx = wr ? wp_pl1 : wp;
		rp_nx = rd ? rp_pl1 : rp;

		// guard bit tells full from empty when the pointers meet
		gb_nx = gb;
		if (wr && !rd && (wp_pl1 == rp)) begin
			gb_nx = 1'b1;
		end else if (rd && !wr) begin
			gb_nx = 1'b0;
		end

		// write and read together leave the count unchanged
		cnt_nx = cnt;
		if (wr && !rd) begin
			cnt_nx = cnt + fifo_pkg::count_t'(1);
		end else if (rd && !wr) begin
			cnt_nx = cnt - fifo_pkg::count_t'(1);
		end
	end

	////////////////////////////////////////////////////////////
	// control registers and registered flags
	////////////////////////////////////////////////////////////

	// flags come from the next pointer state so they are exact every cycle
	always_ff @(posedge clk) begin
		if (!rst || clr) begin
			wp <= '0;
			rp <= '0;
			gb <= 1'b0;
			cnt <= '0;
			empty <= 1'b1;
			full <= 1'b0;
			almost_full <= 1'b0;
			rd_q <= 1'b0;
		end else begin
			wp <= wp_nx;
			rp <= rp_nx;
			gb <= gb_nx;
			cnt <= cnt_nx;
			empty <= (wp_nx == rp_nx) && !gb_nx;
			full <= (wp_nx == rp_nx) && gb_nx;
			almost_full <= (cnt_nx >= fifo_pkg::AFULL_AT);
			rd_q <= rd;
		end
	end

	////////////////////////////////////////////////////////////
	// read data and fill level
	////////////////////////////////////////////////////////////

	// keep the last popped word until the next pop
	always_ff @(posedge clk) begin
		if (rd_q) begin
			hold <= ram_q;
		end
	end

	// fresh ram data right after a pop, held copy otherwise
	assign rdata = rd_q ? ram_q : hold;

	// quarter level from the counter top bits
	// a full fifo sets the top count bit and reads 3
	assign level = {2{cnt[fifo_pkg::PTR_W]}} | cnt[fifo_pkg::PTR_W-1 -: 2];

endmodule

// ==== src/lane_reducer.sv ====
////////////////////////////////////////////////////////////
// ingress to egress mover with lane sum
////////////////////////////////////////////////////////////

module lane_reducer (
	input  logic                clk,
	input  logic                rst,
	input  logic                clr,
	input  logic                in_empty,
	output logic                in_rd,
	input  stream_pkg::word_t   in_word,
	input  logic                out_full,
	input  logic                out_almost_full,
	output logic                out_wr,
	output stream_pkg::sum_t    out_sum
);

	// one word popped last cycle, its sum is written this cycle
	logic busy;

	////////////////////////////////////////////////////////////
	// pop decision
	////////////////////////////////////////////////////////////

	// egress must have room for the new item and any item in flight
	// idle needs one free slot, busy needs two
	always_comb begin
		in_rd = 1'b0;
		if (!clr && !in_empty) begin
			if (busy) begin
				in_rd = !out_almost_full;
			end else begin
				in_rd = !out_full;
			end
		end
	end

	// in flight slot
	// clr drops the item, the egress ignores the write in that cycle
	always_ff @(posedge clk) begin
		if (!rst || clr) begin
			busy <= 1'b0;
		end else begin
			busy <= in_rd;
		end
	end

	////////////////////////////////////////////////////////////
	// lane sum
	////////////////////////////////////////////////////////////

	// ingress read data is valid the cycle after the pop
	// so the sum goes out in the same cycle the item is in flight
	always_comb begin
		out_sum = '0;
		for (int i = 0; i < stream_pkg::LANES; i++) begin
			// carries past bit 31 drop out, sum is modulo 2^32
			out_sum = out_sum + in_word.lane[i];
		end
	end

	// write strobe follows the in flight slot
	assign out_wr = busy;

endmodule

// ==== src/lane_sum_top.sv ====
////////////////////////////////////////////////////////////
// lane sum stream top level
////////////////////////////////////////////////////////////

module lane_sum_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                clr,
	input  logic                in_push,
	input  stream_pkg::word_t   in_data,
	output logic                in_full,
	input  logic                out_pop,
	output stream_pkg::sum_t    out_data,
	output logic                out_empty,
	output fifo_pkg::level_t    out_level
);

	// ingress side between fifo and reducer
	logic ing_rd;
	logic ing_empty;
	stream_pkg::word_t ing_word;

	// egress side between reducer and fifo
	logic egr_wr;
	stream_pkg::sum_t egr_sum;
	logic egr_full;
	logic egr_afull;

	// host words in, 128 bits wide
	// host pushes only while in_full is low
	sc_fifo #(
		.WIDTH (stream_pkg::WORD_W)
	) i_ingress_fifo (
		.clk         (clk),
		.rst         (rst),
		.clr         (clr),
		.wr          (in_push),
		.wdata       (in_data),
		.rd          (ing_rd),
		.rdata       (ing_word),
		.empty       (ing_empty),
		.full        (in_full),
		.almost_full (),
		.level       ()
	);

	// pops words and writes their sums one cycle later
	lane_reducer i_lane_reducer (
		.clk             (clk),
		.rst             (rst),
		.clr             (clr),
		.in_empty        (ing_empty),
		.in_rd           (ing_rd),
		.in_word         (ing_word),
		.out_full        (egr_full),
		.out_almost_full (egr_afull),
		.out_wr          (egr_wr),
		.out_sum         (egr_sum)
	);

	// sums out, 32 bits wide
	sc_fifo #(
		.WIDTH (stream_pkg::LANE_W)
	) i_egress_fifo (
		.clk         (clk),
		.rst         (rst),
		.clr         (clr),
		.wr          (egr_wr),
		.wdata       (egr_sum),
		.rd          (out_pop),
		.rdata       (out_data),
		.empty       (out_empty),
		.full        (egr_full),
		.almost_full (egr_afull),
		.level       (out_level)
	);

endmodule

// ==== dv/lane_sum_checker.sv ====
////////////////////////////////////////////////////////////
// lane sum stream checker with expected sum model
////////////////////////////////////////////////////////////

module lane_sum_checker (
	input logic               clk,
	input logic               rst,
	input logic               clr,
	input logic               in_push,
	input stream_pkg::word_t  in_data,
	input logic               in_full,
	input logic               out_pop,
	input stream_pkg::sum_t   out_data,
	input logic               out_empty,
	input fifo_pkg::level_t   out_level,
	input logic               egr_wr
);

	timeunit 1ns;
	timeprecision 100ps;

	// words the two fifos and the in flight slot hold together
	localparam int TOTAL_CAP = 2 * fifo_pkg::DEPTH;
	localparam int QUARTER = fifo_pkg::DEPTH / 4;

	// count of failed assertions, read by the testbench
	int fail_cnt = 0;

	// expected sums of accepted pushes, oldest first
	stream_pkg::sum_t exp_q[$];
	int exp_cnt;
	// sums sitting in the egress fifo
	int egr_cnt;
	// sum the host popped last
	stream_pkg::sum_t exp_data;
	logic data_valid;
	// no pop since the stream was last empty
	logic pop_free;

	logic push_ok;
	logic pop_ok;

	assign push_ok = in_push && !in_full;
	assign pop_ok = out_pop && !out_empty;

	// lanes added in a wide accumulator, low 32 bits kept
	function automatic stream_pkg::sum_t expected_sum(input stream_pkg::word_t w);
		logic [63:0] acc;
		acc = '0;
		for (int i = 0; i < stream_pkg::LANES; i++) begin
			acc = acc + 64'(w.lane[i]);
		end
		return stream_pkg::sum_t'(acc);
	endfunction

	// quarter rule, 3 from three quarters up
	function automatic fifo_pkg::level_t quarter_level(input int n);
		if (n >= 3 * QUARTER) begin
			return 2'd3;
		end
		return fifo_pkg::level_t'(n / QUARTER);
	endfunction

	////////////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (!rst || clr) begin
			exp_q.delete();
			exp_cnt <= 0;
			egr_cnt <= 0;
			pop_free <= 1'b1;
			if (!rst) begin
				data_valid <= 1'b0;
			end
		end else begin
			// pop before push so the head is the oldest sum
			if (pop_ok && exp_q.size() != 0) begin
				exp_data <= exp_q.pop_front();
				data_valid <= 1'b1;
			end
			if (push_ok) begin
				exp_q.push_back(expected_sum(in_data));
			end
			exp_cnt <= exp_q.size();
			egr_cnt <= egr_cnt + int'(egr_wr) - int'(pop_ok);
			if (exp_q.size() == 0) begin
				pop_free <= 1'b1;
			end else if (pop_ok) begin
				pop_free <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// assertions
	////////////////////////////////////////////////////////////

	// flags right after reset release
	reset_state: assert property (@(posedge clk)
		$rose(rst) |-> out_empty && !in_full && out_level == '0)
		else begin
			fail_cnt++;
			$error("** Error reset_state: expected empty 1 full 0 level 0, actual %b %b %0d",
				$sampled(out_empty), $sampled(in_full), $sampled(out_level));
		end

	// popped data matches the model and holds until the next pop
	sum_order: assert property (@(posedge clk) disable iff (!rst)
		data_valid |-> out_data == exp_data)
		else begin
			fail_cnt++;
			$error("** Error sum_order: expected %08h, actual %08h",
				$sampled(exp_data), $sampled(out_data));
		end

	// a pop needs a push that is still outstanding
	no_extra_sum: assert property (@(posedge clk) disable iff (!rst)
		pop_ok |-> exp_cnt != 0)
		else begin
			fail_cnt++;
			$error("** Error no_extra_sum: a sum was popped with no push outstanding");
		end

	// egress empty flag against the model count
	egress_empty: assert property (@(posedge clk) disable iff (!rst)
		out_empty == (egr_cnt == 0))
		else begin
			fail_cnt++;
			$error("** Error egress_empty: expected %b, actual %b",
				$sampled(egr_cnt) == 0, $sampled(out_empty));
		end

	// fill level by the quarter rule
	level: assert property (@(posedge clk) disable iff (!rst)
		out_level == quarter_level(egr_cnt))
		else begin
			fail_cnt++;
			$error("** Error level: expected %0d, actual %0d",
				quarter_level($sampled(egr_cnt)), $sampled(out_level));
		end

	// without pops the ingress reports full exactly at total capacity
	back_pressure: assert property (@(posedge clk) disable iff (!rst)
		pop_free |-> in_full == (exp_cnt == TOTAL_CAP))
		else begin
			fail_cnt++;
			$error("** Error back_pressure: expected in_full %b, actual %b at %0d words",
				$sampled(exp_cnt) == TOTAL_CAP, $sampled(in_full), $sampled(exp_cnt));
		end

	// one clr cycle empties everything
	clear_state: assert property (@(posedge clk) disable iff (!rst)
		clr |=> out_empty && !in_full && out_level == '0)
		else begin
			fail_cnt++;
			$error("** Error clear_state: expected empty 1 full 0 level 0, actual %b %b %0d",
				$sampled(out_empty), $sampled(in_full), $sampled(out_level));
		end

endmodule

bind lane_sum_top lane_sum_checker i_lane_sum_checker (
	.clk       (clk),
	.rst       (rst),
	.clr       (clr),
	.in_push   (in_push),
	.in_data   (in_data),
	.in_full   (in_full),
	.out_pop   (out_pop),
	.out_data  (out_data),
	.out_empty (out_empty),
	.out_level (out_level),
	.egr_wr    (egr_wr)
);

// ==== dv/lane_sum_tb.sv ====
////////////////////////////////////////////////////////////
// lane sum stream testbench
////////////////////////////////////////////////////////////

module lane_sum_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 8;
	localparam int NUM_PHASES = 6;
	localparam int TIMEOUT_NS = 200 * CLK_PERIOD * NUM_PHASES;
	localparam int TOTAL_CAP = 2 * fifo_pkg::DEPTH;

	// word patterns
	localparam int PAT_RANDOM = 0;
	localparam int PAT_MAX = 1;
	localparam int PAT_NEAR_MAX = 2;

	logic clk;
	logic rst;
	logic clr;
	logic in_push;
	stream_pkg::word_t in_data;
	logic in_full;
	logic out_pop;
	stream_pkg::sum_t out_data;
	logic out_empty;
	fifo_pkg::level_t out_level;

	integer seed;
	// sums pushed but not yet popped
	int pending;

	lane_sum_top i_lane_sum_top (
		.clk       (clk),
		.rst       (rst),
		.clr       (clr),
		.in_push   (in_push),
		.in_data   (in_data),
		.in_full   (in_full),
		.out_pop   (out_pop),
		.out_data  (out_data),
		.out_empty (out_empty),
		.out_level (out_level)
	);

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	// lanes all ones wrap the sum several times
	function automatic stream_pkg::word_t make_word(input int pattern);
		stream_pkg::word_t w;
		for (int i = 0; i < stream_pkg::LANES; i++) begin
			case (pattern)
				PAT_MAX: w.lane[i] = '1;
				PAT_NEAR_MAX: w.lane[i] = 32'hffff_ff00 | ($random(seed) & 32'h0000_00ff);
				default: w.lane[i] = $random(seed);
			endcase
		end
		return w;
	endfunction

	task automatic idle(input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			in_push = 1'b0;
			out_pop = 1'b0;
			clr = 1'b0;
		end
	endtask

	// pushes with no pops, waits out in_full
	task automatic push_words(input int n, input int pattern);
		int pushed;
		pushed = 0;
		while (pushed < n) begin
			@(negedge clk);
			in_push = 1'b0;
			out_pop = 1'b0;
			if (!in_full) begin
				in_push = 1'b1;
				in_data = make_word(pattern);
				pushed++;
				pending++;
			end
		end
		idle(1);
	endtask

	// pops until every pushed sum came back
	task automatic drain();
		while (pending > 0) begin
			@(negedge clk);
			in_push = 1'b0;
			out_pop = !out_empty;
			if (!out_empty) begin
				pending--;
			end
		end
		idle(1);
	endtask

	// push every cycle and pop whenever a sum is there
	task automatic stream(input int n);
		int pushed;
		pushed = 0;
		while (pushed < n || pending > 0) begin
			@(negedge clk);
			in_push = 1'b0;
			out_pop = 1'b0;
			if (pushed < n && !in_full) begin
				in_push = 1'b1;
				in_data = make_word(PAT_RANDOM);
				pushed++;
				pending++;
			end
			if (!out_empty) begin
				out_pop = 1'b1;
				pending--;
			end
		end
		idle(1);
	endtask

	// push with no pops until the ingress reports full
	task automatic fill_until_full();
		int pushed;
		pushed = 0;
		@(negedge clk);
		while (!in_full && pushed <= TOTAL_CAP) begin
			in_push = 1'b1;
			in_data = make_word(PAT_RANDOM);
			pushed++;
			pending++;
			@(negedge clk);
		end
		in_push = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	initial begin
		seed = 95;
		rst = 1'b0;
		clr = 1'b0;
		in_push = 1'b0;
		in_data = '0;
		out_pop = 1'b0;
		pending = 0;
		repeat (2) @(negedge clk);
		rst = 1'b1;

		$display("phase reset_state");
		idle(4);

		$display("phase sum_order");
		push_words(8, PAT_RANDOM);
		drain();

		// sums past 2^32
		$display("phase wrap");
		push_words(4, PAT_MAX);
		push_words(6, PAT_NEAR_MAX);
		drain();

		$display("phase streaming");
		stream(64);

		// egress fills first, then the ingress
		$display("phase back_pressure");
		fill_until_full();
		idle(4);
		drain();

		// egress full and a few words left in the ingress
		$display("phase clear");
		push_words(20, PAT_RANDOM);
		@(negedge clk);
		clr = 1'b1;
		@(negedge clk);
		clr = 1'b0;
		pending = 0;
		idle(2);
		stream(16);
		idle(4);

		if (i_lane_sum_top.i_lane_sum_checker.fail_cnt == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("Test failures found");
			$fatal(1, "checker reported failed assertions");
		end
	end

	// stop at the first failed assertion
	initial begin
		wait (i_lane_sum_top.i_lane_sum_checker.fail_cnt != 0);
		$display("Test failures found");
		$fatal(1, "checker assertion failed at %0t", $time);
	end

	// watchdog
	initial begin
		#(TIMEOUT_NS);
		$display("Test failures found");
		$fatal(1, "watchdog timeout, run did not finish within %0d ns", TIMEOUT_NS);
	end

endmodule

// ==== files.f ====
src/fifo_pkg.sv
src/stream_pkg.sv
src/sync_ram.sv
src/sc_fifo.sv
src/lane_reducer.sv
src/lane_sum_top.sv
dv/lane_sum_checker.sv
dv/lane_sum_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lane_sum_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= All tests passed!

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o V$(TOP)

# status comes from grep, so a run without the pass line fails
sim: build
	$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
